// ==== src.f ====
cpu_pkg.sv
fetch.sv
data_port.sv
mem_arbiter.sv
unified_mem.sv
fetch_sub_top.sv
tb_fetch_sva.sv
tb_checker.sv
tb_fetch.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_fetch -o sim_fetch

out=$(./obj_dir/sim_fetch)
echo "$out"

if echo "$out" | grep -q "Simulation PASSED"; then
  exit 0
fi
exit 1

// ==== tb_fetch.sv ====
module tb_fetch;
  timeunit 1ns;
  timeprecision 1ps;
  import cpu_pkg::*;

  localparam int NUM_TESTS = 17;

  // op: 0 none, 1 load, 2 store, 3 random load or store
  typedef struct packed {
    pc_src_t     src;
    logic [15:0] br;
    logic        excp;
    logic [15:0] exi;
    logic        stall;
    logic [1:0]  op;
    logic [15:0] daddr;
    logic [15:0] wd;
    logic        exp_err;
    logic [7:0]  reps;
  } entry_t;

  logic        clk;
  logic        arst_n;
  pc_src_t     pc_src;
  logic [15:0] branch_pc;
  logic        excp;
  logic        stall_decode;
  logic [15:0] ex_instruction;
  logic [15:0] instruction;
  logic [15:0] pc_out;
  logic        instr_valid;
  logic        misalign;
  logic        ld;
  logic        st;
  logic [15:0] addr;
  logic [15:0] wdata;
  logic [15:0] rdata;
  logic        dp_done;
  logic        dp_err;

  entry_t      tests [NUM_TESTS];
  string       names [NUM_TESTS];
  int          n_fill = 0;
  int          cycles = 0;
  int          limit = 0;

  fetch_sub_top dut0 (.*);
  tb_checker chk0 (.*);

  bind mem_arbiter tb_fetch_sva sva0 (
    .clk(clk), .arst_n(arst_n), .owner(owner_q), .if_req(if_req), .dp_req(dp_req),
    .if_rsp(if_rsp), .dp_rsp(dp_rsp), .mem_rsp(mem_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // run limit, derived from the table length
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles >= limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic add(input string name, input pc_src_t src, input logic [15:0] br,
                     input logic ex, input logic [15:0] exi, input logic stall,
                     input logic [1:0] op, input logic [15:0] a, input logic [15:0] d,
                     input logic exp_err, input logic [7:0] reps);
    names[n_fill] = name;
    tests[n_fill] = '{src, br, ex, exi, stall, op, a, d, exp_err, reps};
    n_fill++;
  endtask

  // apply one entry, each repeat waits for its instruction and data result
  task automatic run_entry(input int i);
    entry_t e;
    logic   got_instr;
    logic   got_data;
    e = tests[i];
    pc_src = e.src;
    branch_pc = e.br;
    excp = e.excp;
    ex_instruction = e.exi;
    stall_decode = e.stall;
    for (int r = 0; r < int'(e.reps); r++) begin
      got_instr = 1'b0;
      got_data = (e.op == 2'd0);
      if (e.op == 2'd3) begin
        ld = 1'($urandom % 2);
        st = ~ld;
        addr = 16'(32'h0180 + (($urandom % 64) << 1));
        wdata = 16'($urandom);
      end else begin
        ld = (e.op == 2'd1);
        st = (e.op == 2'd2);
        addr = e.daddr;
        wdata = e.wd;
      end
      while (!(got_instr && got_data)) begin
        @(negedge clk);
        // single-cycle strobes
        ld = 1'b0;
        st = 1'b0;
        if (e.exp_err ? misalign : instr_valid) got_instr = 1'b1;
        if (dp_done) got_data = 1'b1;
      end
    end
    // let the checker see the last result first
    @(negedge clk);
    chk0.end_test(names[i]);
  endtask

  initial begin
    arst_n = 1'b0;
    pc_src = PC_SEQ;
    branch_pc = '0;
    excp = 1'b0;
    stall_decode = 1'b0;
    ex_instruction = '0;
    ld = 1'b0;
    st = 1'b0;
    addr = '0;
    wdata = '0;
    void'($urandom(32'h520652e3));

    //  name            src        br     ex exi    stall op addr  wdata  err reps
    add("seq",          PC_SEQ,    '0,    0, '0,    0, 0, '0,      '0,    0, 4);
    add("branch",       PC_BRANCH, 16'h0020, 0, '0, 0, 0, '0,      '0,    0, 1);
    add("seq_after_br", PC_SEQ,    '0,    0, '0,    0, 0, '0,      '0,    0, 2);
    add("branch_odd",   PC_BRANCH, 16'h0031, 0, '0, 0, 0, '0,      '0,    0, 1);
    add("misalign",     PC_SEQ,    '0,    0, '0,    0, 0, '0,      '0,    1, 1);
    add("recover",      PC_BRANCH, 16'h0010, 0, '0, 0, 0, '0,      '0,    0, 1);
    add("exception",    PC_EXC,    '0,    1, '0,    0, 0, '0,      '0,    0, 1);
    add("handler",      PC_SEQ,    '0,    0, '0,    0, 0, '0,      '0,    0, 2);
    // opcode 00011 in bits [15:11]
    add("rti",          PC_SEQ,    '0,    0, 16'h1800, 0, 0, '0,   '0,    0, 1);
    add("hold",         PC_HOLD,   '0,    0, '0,    0, 0, '0,      '0,    0, 3);
    add("stall",        PC_SEQ,    '0,    0, '0,    1, 0, '0,      '0,    0, 3);
    add("store",        PC_SEQ,    '0,    0, '0,    0, 2, 16'h0100, 16'hBEEF, 0, 1);
    add("load",         PC_SEQ,    '0,    0, '0,    0, 1, 16'h0100, '0,   0, 1);
    // odd data address, memory answers with err
    add("load_odd",     PC_SEQ,    '0,    0, '0,    0, 1, 16'h0103, '0,   0, 1);
    add("jump_stored",  PC_BRANCH, 16'h0100, 0, '0, 0, 0, '0,      '0,    0, 1);
    add("fetch_stored", PC_HOLD,   '0,    0, '0,    0, 0, '0,      '0,    0, 1);
    add("random_mix",   PC_SEQ,    '0,    0, '0,    0, 3, '0,      '0,    0, 8);

    // reset cycles plus a budget per entry
    limit = 10;
    for (int i = 0; i < NUM_TESTS; i++) begin
      limit += int'(tests[i].reps) * 4 * MEM_LAT + 10;
    end

    repeat (10) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    for (int i = 0; i < NUM_TESTS; i++) begin
      run_entry(i);
    end

    $display("checks: %0d  errors: %0d", chk0.checks, chk0.errors);
    if (chk0.errors == 0 && chk0.checks > 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== tb_checker.sv ====
module tb_checker (
  input logic                       clk,
  input logic                       arst_n,
  input cpu_pkg::pc_src_t           pc_src,
  input logic [cpu_pkg::WORD_W-1:0] branch_pc,
  input logic                       excp,
  input logic                       stall_decode,
  input logic [cpu_pkg::WORD_W-1:0] ex_instruction,
  input logic [cpu_pkg::WORD_W-1:0] instruction,
  input logic [cpu_pkg::WORD_W-1:0] pc_out,
  input logic                       instr_valid,
  input logic                       misalign,
  input logic                       ld,
  input logic                       st,
  input logic [cpu_pkg::WORD_W-1:0] addr,
  input logic [cpu_pkg::WORD_W-1:0] wdata,
  input logic [cpu_pkg::WORD_W-1:0] rdata,
  input logic                       dp_done,
  input logic                       dp_err
);
  timeunit 1ns;
  timeprecision 1ps;
  import cpu_pkg::*;

  // predicted PC and EPC
  logic [15:0] exp_pc;
  logic [15:0] exp_epc;
  // words written so far, by word index
  logic [15:0] written [int];
  // inputs as seen at the previous edge, the one that completed the fetch
  pc_src_t     l_src;
  logic [15:0] l_br;
  logic [15:0] l_exi;
  logic        l_excp;
  logic        l_stall;
  // outstanding data access
  logic        dp_busy;
  logic        dp_is_ld;
  logic [15:0] dp_addr;
  logic [15:0] dp_wdata;
  int errors = 0;
  int checks = 0;
  int mark_err = 0;
  int mark_chk = 0;

  function automatic logic [15:0] mem_word(input logic [15:0] a);
    int idx;
    idx = int'(a[15:1]) % MEM_WORDS;
    if (written.exists(idx)) return written[idx];
    // untouched words keep the seed pattern
    return a ^ MEM_SEED;
  endfunction

  task automatic check(input logic [15:0] got, input logic [15:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // next PC after a completed read, err acts as hold for sequential flow
  task automatic step_pc(input logic err);
    logic [15:0] nxt;
    logic        rti;
    if (l_stall) return;
    rti = (l_exi[15:11] == OP_RTI);
    case (l_src)
      PC_HOLD: nxt = exp_pc;
      PC_SEQ: nxt = err ? exp_pc : exp_pc + 16'd2;
      PC_BRANCH: nxt = l_br;
      default: nxt = l_excp ? EXC_VECTOR : exp_epc;
    endcase
    if (rti) nxt = exp_epc;
    if (!rti && l_src == PC_EXC && l_excp) exp_epc = exp_pc;
    exp_pc = nxt;
  endtask

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      exp_pc = START_PC;
      exp_epc = START_PC;
      dp_busy = 1'b0;
      written.delete();
    end else begin
      if (instr_valid) begin
        check(pc_out, exp_pc, "pc_out");
        check(instruction, mem_word(exp_pc), "instruction");
        step_pc(1'b0);
      end
      if (misalign) begin
        checks++;
        if (!exp_pc[0]) begin
          errors++;
          $display("misalign raised at %0t although pc %h is even", $time, exp_pc);
        end
        step_pc(1'b1);
      end
      if (dp_done) begin
        if (!dp_busy) begin
          errors++;
          $display("data port finished at %0t with no access pending", $time);
        end else begin
          check(16'(dp_err), 16'(dp_addr[0]), "dp_err");
          if (dp_is_ld && !dp_addr[0]) check(rdata, mem_word(dp_addr), "load data");
          if (!dp_is_ld && !dp_addr[0]) written[int'(dp_addr[15:1]) % MEM_WORDS] = dp_wdata;
          dp_busy = 1'b0;
        end
      end
      if ((ld || st) && !dp_busy) begin
        dp_busy = 1'b1;
        dp_is_ld = ld;
        dp_addr = addr;
        dp_wdata = wdata;
      end
      l_src = pc_src;
      l_br = branch_pc;
      l_exi = ex_instruction;
      l_excp = excp;
      l_stall = stall_decode;
    end
  end

  // one summary line per finished test
  task automatic end_test(input string name);
    if (errors == mark_err) $display("test %-16s ok      %0d checks", name, checks - mark_chk);
    else $display("test %-16s failed  %0d errors", name, errors - mark_err);
    mark_err = errors;
    mark_chk = checks;
  endtask

endmodule

// ==== tb_fetch_sva.sv ====
module tb_fetch_sva (
  input logic              clk,
  input logic              arst_n,
  input logic [1:0]        owner,
  input cpu_pkg::mem_req_t if_req,
  input cpu_pkg::mem_req_t dp_req,
  input cpu_pkg::mem_rsp_t if_rsp,
  input cpu_pkg::mem_rsp_t dp_rsp,
  input cpu_pkg::mem_rsp_t mem_rsp
);
  timeunit 1ns;
  timeprecision 1ps;

  // a held grant is neither dropped nor handed over before its done pulse
  one_grant: assert property (@(posedge clk) disable iff (!arst_n)
    (owner != 2'b00 && !mem_rsp.done) |=> owner == $past(owner))
    else $error("grant changed hands before the memory finished");

  // a pending request keeps its address and data until done
  if_stable: assert property (@(posedge clk) disable iff (!arst_n)
    (if_req.rd && !if_rsp.done) |=> $stable(if_req))
    else $error("fetch request changed before its done pulse");
  dp_stable: assert property (@(posedge clk) disable iff (!arst_n)
    ((dp_req.rd || dp_req.wr) && !dp_rsp.done) |=> $stable(dp_req))
    else $error("data request changed before its done pulse");

  // memory only finishes while some requester holds the grant
  done_granted: assert property (@(posedge clk) disable iff (!arst_n)
    mem_rsp.done |-> owner != 2'b00)
    else $error("memory gave done while no grant was held");

  // done reaches a requester only for a request it still holds
  if_done_req: assert property (@(posedge clk) disable iff (!arst_n)
    if_rsp.done |-> if_req.rd)
    else $error("fetch got done with no read pending");
  dp_done_req: assert property (@(posedge clk) disable iff (!arst_n)
    dp_rsp.done |-> (dp_req.rd || dp_req.wr))
    else $error("data port got done with no access pending");

endmodule

// ==== fetch_sub_top.sv ====
module fetch_sub_top (
  input  logic                       clk,
  input  logic                       arst_n,
  input  cpu_pkg::pc_src_t           pc_src,
  input  logic [cpu_pkg::WORD_W-1:0] branch_pc,
  input  logic                       excp,
  input  logic                       stall_decode,
  input  logic [cpu_pkg::WORD_W-1:0] ex_instruction,
  output logic [cpu_pkg::WORD_W-1:0] instruction,
  output logic [cpu_pkg::WORD_W-1:0] pc_out,
  output logic                       instr_valid,
  output logic                       misalign,
  input  logic                       ld,
  input  logic                       st,
  input  logic [cpu_pkg::WORD_W-1:0] addr,
  input  logic [cpu_pkg::WORD_W-1:0] wdata,
  output logic [cpu_pkg::WORD_W-1:0] rdata,
  output logic                       dp_done,
  output logic                       dp_err
);
  import cpu_pkg::*;

  // requester side links
  mem_req_t if_req;
  mem_rsp_t if_rsp;
  mem_req_t dp_req;
  mem_rsp_t dp_rsp;
  // shared memory link
  mem_req_t mem_req;
  mem_rsp_t mem_rsp;

  fetch u_fetch (
    .clk, .arst_n, .pc_src, .branch_pc, .excp, .stall_decode, .ex_instruction,
    .if_req, .if_rsp, .instruction, .pc_out, .instr_valid, .misalign
  );

  data_port u_data_port (
    .clk, .arst_n, .ld, .st, .addr, .wdata, .dp_req, .dp_rsp, .rdata, .dp_done, .dp_err
  );

  // one memory, data port has priority over fetch
  mem_arbiter u_arb (
    .clk, .arst_n, .if_req, .if_rsp, .dp_req, .dp_rsp, .mem_req, .mem_rsp
  );

  unified_mem u_mem (
    .clk, .arst_n, .mem_req, .mem_rsp
  );

endmodule

// ==== unified_mem.sv ====
module unified_mem (
  input  logic              clk,
  input  logic              arst_n,
  input  cpu_pkg::mem_req_t mem_req,
  output cpu_pkg::mem_rsp_t mem_rsp
);
  import cpu_pkg::*;

  logic [WORD_W-1:0] mem [MEM_WORDS];
  // access latched at start
  mem_req_t          acc_q;
  // cycles left, zero when idle
  logic [LAT_W-1:0]  cnt;
  logic              done_q;
  logic              err_q;
  logic [WORD_W-1:0] rdata_q;
  logic              start;
  logic              fire;
  logic [MEM_AW-1:0] idx;

  // no new access during the done cycle, the requester still holds its level
  assign start = (cnt == '0) & ~done_q & (mem_req.rd | mem_req.wr);

  // last edge of the countdown, the access happens here
  assign fire = (cnt == LAT_W'(1));

  // byte address to word index, upper bits wrap
  assign idx = acc_q.addr[MEM_AW:1];

  // countdown and response strobes
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt    <= '0;
      done_q <= 1'b0;
      err_q  <= 1'b0;
    end else begin
      done_q <= fire;
      // odd address is flagged instead of served
      err_q  <= fire & acc_q.addr[0];
      if (start) begin
        cnt <= LAT_W'(MEM_LAT - 1);
      end else if (cnt != '0) begin
        cnt <= cnt - LAT_W'(1);
      end
    end
  end

  // storage, preset with the seed pattern on reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= WORD_W'(2 * i) ^ MEM_SEED;
      end
    end else if (fire && acc_q.wr && !acc_q.addr[0]) begin
      mem[idx] <= acc_q.wdata;
    end
  end

  // request capture and read data
  always_ff @(posedge clk) begin
    if (start) begin
      acc_q <= mem_req;
    end
    if (fire && acc_q.rd && !acc_q.addr[0]) begin
      rdata_q <= mem[idx];
    end
  end

  assign mem_rsp = '{done: done_q, err: err_q, rdata: rdata_q};

endmodule

// ==== mem_arbiter.sv ====
module mem_arbiter (
  input  logic              clk,
  input  logic              arst_n,
  input  cpu_pkg::mem_req_t if_req,
  output cpu_pkg::mem_rsp_t if_rsp,
  input  cpu_pkg::mem_req_t dp_req,
  output cpu_pkg::mem_rsp_t dp_rsp,
  output cpu_pkg::mem_req_t mem_req,
  input  cpu_pkg::mem_rsp_t mem_rsp
);
  import cpu_pkg::*;

  // who owns the memory
  typedef enum logic [1:0] {
    OWN_IDLE  = 2'b00,
    OWN_FETCH = 2'b01,
    OWN_DATA  = 2'b10
  } owner_t;

  owner_t owner_q;
  owner_t sel;
  logic   if_wants;
  logic   dp_wants;

  assign if_wants = if_req.rd | if_req.wr;
  assign dp_wants = dp_req.rd | dp_req.wr;

  // grant in the same cycle when idle, data port first
  always_comb begin
    sel = owner_q;
    if (owner_q == OWN_IDLE) begin
      if (dp_wants) begin
        sel = OWN_DATA;
      end else if (if_wants) begin
        sel = OWN_FETCH;
      end
    end
  end

  // request mux towards memory
  always_comb begin
    unique case (sel)
      OWN_DATA: begin
        mem_req = dp_req;
      end
      OWN_FETCH: begin
        mem_req = if_req;
      end
      default: begin
        mem_req = '0;
      end
    endcase
  end

  // response goes back only to the current owner
  // done can only arrive while an owner is held
  assign if_rsp = (owner_q == OWN_FETCH) ? mem_rsp : '0;
  assign dp_rsp = (owner_q == OWN_DATA) ? mem_rsp : '0;

  // owner is kept through the done cycle, idle after it
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      owner_q <= OWN_IDLE;
    end else if (owner_q == OWN_IDLE) begin
      owner_q <= sel;
    end else if (mem_rsp.done) begin
      owner_q <= OWN_IDLE;
    end
  end

endmodule

// ==== data_port.sv ====
module data_port (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       ld,
  input  logic                       st,
  input  logic [cpu_pkg::WORD_W-1:0] addr,
  input  logic [cpu_pkg::WORD_W-1:0] wdata,
  output cpu_pkg::mem_req_t          dp_req,
  input  cpu_pkg::mem_rsp_t          dp_rsp,
  output logic [cpu_pkg::WORD_W-1:0] rdata,
  output logic                       dp_done,
  output logic                       dp_err
);
  import cpu_pkg::*;

  // pending access, one at a time
  logic              pend_rd;
  logic              pend_wr;
  logic [WORD_W-1:0] pend_addr;
  logic [WORD_W-1:0] pend_wdata;
  logic              pending;
  logic              accept;

  assign pending = pend_rd | pend_wr;

  // new pulses only count while nothing is outstanding
  assign accept = ~pending & (ld | st);

  // request flags and completion strobes
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pend_rd <= 1'b0;
      pend_wr <= 1'b0;
      dp_done <= 1'b0;
      dp_err  <= 1'b0;
    end else begin
      // arbiter only forwards done while this port holds the grant
      dp_done <= dp_rsp.done;
      dp_err  <= dp_rsp.done & dp_rsp.err;
      if (accept) begin
        // load wins if both strobes arrive together
        pend_rd <= ld;
        pend_wr <= st & ~ld;
      end else if (dp_rsp.done) begin
        pend_rd <= 1'b0;
        pend_wr <= 1'b0;
      end
    end
  end

  // address, store data and load result
  always_ff @(posedge clk) begin
    if (accept) begin
      pend_addr  <= addr;
      pend_wdata <= wdata;
    end
    if (dp_rsp.done && pend_rd) begin
      rdata <= dp_rsp.rdata;
    end
  end

  // held as a level until the done pulse
  assign dp_req = '{rd: pend_rd, wr: pend_wr, addr: pend_addr, wdata: pend_wdata};

endmodule

// ==== fetch.sv ====
module fetch (
  input  logic                       clk,
  input  logic                       arst_n,
  input  cpu_pkg::pc_src_t           pc_src,
  input  logic [cpu_pkg::WORD_W-1:0] branch_pc,
  input  logic                       excp,
  input  logic                       stall_decode,
  input  logic [cpu_pkg::WORD_W-1:0] ex_instruction,
  output cpu_pkg::mem_req_t          if_req,
  input  cpu_pkg::mem_rsp_t          if_rsp,
  output logic [cpu_pkg::WORD_W-1:0] instruction,
  output logic [cpu_pkg::WORD_W-1:0] pc_out,
  output logic                       instr_valid,
  output logic                       misalign
);
  import cpu_pkg::*;

  // current fetch address and saved exception return address
  logic [WORD_W-1:0] pc_q;
  logic [WORD_W-1:0] epc_q;
  logic [WORD_W-1:0] next_pc;
  // read request enable, low while in reset
  logic              fetch_en;
  logic [4:0]        opcode;
  logic              is_rti;
  logic              advance;
  logic              take_exc;

  // opcode of the instruction now in execute
  assign opcode = ex_instruction[WORD_W-1 -: 5];
  assign is_rti = (opcode == OP_RTI);

  // PC moves only on a completed read that decode can accept
  assign advance = if_rsp.done & ~stall_decode;

  // entering the handler, rti in execute wins over it
  assign take_exc = ~is_rti & (pc_src == PC_EXC) & excp;

  // next PC selection
  always_comb begin
    next_pc = pc_q;
    if (is_rti) begin
      // rti overrides whatever pc_src says
      next_pc = epc_q;
    end else begin
      unique case (pc_src)
        PC_HOLD: begin
          // halt, keep refetching the same word
          next_pc = pc_q;
        end
        PC_SEQ: begin
          // a misaligned read does not step past the bad address
          next_pc = if_rsp.err ? pc_q : pc_q + WORD_W'(2);
        end
        PC_BRANCH: begin
          next_pc = branch_pc;
        end
        PC_EXC: begin
          // vector on a new exception, else return through EPC
          next_pc = excp ? EXC_VECTOR : epc_q;
        end
      endcase
    end
  end

  // PC, EPC and the result strobes
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc_q        <= START_PC;
      epc_q       <= START_PC;
      pc_out      <= START_PC;
      fetch_en    <= 1'b0;
      instr_valid <= 1'b0;
      misalign    <= 1'b0;
    end else begin
      fetch_en    <= 1'b1;
      // every good read is reported, refetches included
      instr_valid <= if_rsp.done & ~if_rsp.err;
      misalign    <= if_rsp.done & if_rsp.err;
      if (if_rsp.done && !if_rsp.err) begin
        // address the captured word came from
        pc_out <= pc_q;
      end
      if (advance) begin
        pc_q <= next_pc;
        if (take_exc) begin
          epc_q <= pc_q;
        end
      end
    end
  end

  // fetched word, captured with instr_valid
  always_ff @(posedge clk) begin
    if (if_rsp.done && !if_rsp.err) begin
      instruction <= if_rsp.rdata;
    end
  end

  // read-only requester, address stays put until done
  assign if_req = '{rd: fetch_en, wr: 1'b0, addr: pc_q, wdata: '0};

endmodule

// ==== cpu_pkg.sv ====
package cpu_pkg;

  // datapath and address width
  localparam int WORD_W = 16;

  // PC value after reset
  localparam logic [WORD_W-1:0] START_PC = 16'h0000;
  // exception handler entry
  localparam logic [WORD_W-1:0] EXC_VECTOR = 16'h0002;

  // cycles from grant to done, two or more
  localparam int MEM_LAT = 2;
  // countdown width inside the memory
  localparam int LAT_W = $clog2(MEM_LAT + 1);

  // memory depth in 16-bit words
  localparam int MEM_WORDS = 256;
  // word index width, byte address bits [MEM_AW:1]
  localparam int MEM_AW = $clog2(MEM_WORDS);

  // return-from-interrupt opcode, instruction bits [15:11]
  localparam logic [4:0] OP_RTI = 5'b00011;

  // unwritten word at byte address a reads as a ^ MEM_SEED
  localparam logic [WORD_W-1:0] MEM_SEED = 16'hA5A5;

  // next-PC source from the execute stage
  typedef enum logic [1:0] {
    PC_HOLD   = 2'b00,
    PC_SEQ    = 2'b01,
    PC_BRANCH = 2'b10,
    PC_EXC    = 2'b11
  } pc_src_t;

  // request level, held until done
  typedef struct packed {
    logic              rd;
    logic              wr;
    logic [WORD_W-1:0] addr;
    logic [WORD_W-1:0] wdata;
  } mem_req_t;

  // response, done is a single-cycle pulse
  typedef struct packed {
    logic              done;
    logic              err;
    logic [WORD_W-1:0] rdata;
  } mem_rsp_t;

endpackage
